/* list.f */
hdl/noc_pkt_pkg.sv
hdl/host_cfg_pkg.sv
hdl/spmd_fetch.sv
hdl/spmd_pkt_builder.sv
hdl/net_egress_buf.sv
hdl/south_edge_monitor.sv
hdl/host_top.sv
test/tb_host_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the host testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_host_top -f list.f -o tb_host_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_host_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TEST PASS$"; then
  exit 0
fi
exit 1

/* test/tb_host_top.sv */
`timescale 1ns/1ps

module tb_host_top;
  import noc_pkt_pkg::*;

  localparam int rows_lp       = 2;
  localparam int cols_lp       = 3;
  localparam int words_lp      = 8;
  localparam int max_cycles_lp = 3000;
  localparam int total_lp      = rows_lp * cols_lp * (words_lp + 1);
  localparam int aw_lp         = $clog2(words_lp);

  localparam addr_t finish_addr_lp = 32'h0000_EAD0;
  localparam addr_t fail_addr_lp   = 32'h0000_EAD8;
  localparam addr_t freeze_addr_lp = 32'h0000_FF00;

  logic                   clk;
  logic                   rst_n;
  logic [15:0]            rom_addr;
  data_t                  rom_data;
  noc_pkt_t               net_pkt;
  logic                   net_v;
  logic                   net_ready;
  logic                   load_done;
  noc_pkt_t [cols_lp-1:0] south_pkt;
  logic     [cols_lp-1:0] south_v;
  logic                   finish;
  logic                   fail;
  logic                   timeout;
  data_t                  status_code;

  data_t       rom_mem [words_lp];
  noc_pkt_t    exp_q [$];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          test_err0;

  host_top #(
    .num_rows_p   (rows_lp),
    .num_cols_p   (cols_lp),
    .mem_words_p  (words_lp),
    .max_cycles_p (max_cycles_lp)
  ) uut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .rom_addr_o    (rom_addr),
    .rom_data_i    (rom_data),
    .net_pkt_o     (net_pkt),
    .net_v_o       (net_v),
    .net_ready_i   (net_ready),
    .load_done_o   (load_done),
    .south_pkt_i   (south_pkt),
    .south_v_i     (south_v),
    .finish_o      (finish),
    .fail_o        (fail),
    .timeout_o     (timeout),
    .status_code_o (status_code)
  );

  // combinational program ROM
  assign rom_data = (rom_addr < 16'(words_lp)) ? rom_mem[rom_addr[aw_lp-1:0]] : '0;

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic noc_pkt_t make_pkt(input op_t op, input addr_t addr, input data_t data,
                                        input logic [3:0] y, input logic [3:0] x);
    noc_pkt_t p;
    p.op     = op;
    p.op_ex  = 4'hF;
    p.addr   = addr;
    p.data   = data;
    p.y_cord = y;
    p.x_cord = x;
    return p;
  endfunction

  task automatic check(input logic ok, input string msg);
    checks++;
    assert (ok) else
    begin
      errors++;
      $display("ERROR at %0t ns: %s", $time, msg);
    end
  endtask

  task automatic timed_out(input string what);
    errors++;
    $display("Gave up at %0t ns after waiting too long for %s", $time, what);
  endtask

  task automatic start_test();
    test_err0 = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors > test_err0)
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_err0);
    end
    else
      $display("test %s: passed", name);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n     = 1'b0;
    net_ready = 1'b0;
    south_v   = '0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
  endtask

  // program words for every tile, then one unfreeze per tile
  task automatic build_expected();
    for (int i = 0; i < words_lp; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      rom_mem[aw_lp'(i)] = lcg_state;
    end
    for (int y = 0; y < rows_lp; y++)
      for (int x = 0; x < cols_lp; x++)
        for (int i = 0; i < words_lp; i++)
          exp_q.push_back(make_pkt(op_store, addr_t'(i * 4), rom_mem[aw_lp'(i)], 4'(y), 4'(x)));
    for (int y = 0; y < rows_lp; y++)
      for (int x = 0; x < cols_lp; x++)
        exp_q.push_back(make_pkt(op_store, freeze_addr_lp, 32'h0, 4'(y), 4'(x)));
  endtask

  task automatic run_load();
    int       idx;
    int       cyc;
    logic     held_v;
    noc_pkt_t held;
    idx    = 0;
    cyc    = 0;
    held_v = 1'b0;
    held   = '0;
    while (idx < total_lp && cyc < 2000)
    begin
      @(posedge clk);
      #1;
      lcg_state = lcg_next(lcg_state);
      net_ready = (lcg_state[17:16] != 2'b00);  // roughly 3 in 4 ready
      @(negedge clk);
      cyc++;
      if (held_v)
        check(net_v && (net_pkt == held), "packet changed while stalled");
      check(!load_done, $sformatf("load_done_o high after only %0d packets", idx));
      check(rom_addr < 16'(words_lp), $sformatf("rom_addr_o %0d is past the program", rom_addr));
      if (net_v && net_ready)
      begin
        check(net_pkt == exp_q[idx],
              $sformatf("packet %0d is %h, expected %h", idx, net_pkt, exp_q[idx]));
        idx++;
      end
      held_v = net_v && !net_ready;
      held   = net_pkt;
    end
    if (idx < total_lp)
      timed_out("the loader packets");
    @(posedge clk);
    #1 net_ready = 1'b1;
    @(negedge clk);
    check(load_done, "load_done_o low after the last packet");
    repeat (20)
    begin
      @(negedge clk);
      check(!net_v, "extra packet after the last expected one");
      check(load_done, "load_done_o dropped");
    end
  endtask

  task automatic run_monitor();
    @(posedge clk);
    #1;
    south_pkt[0] = make_pkt(op_store, 32'h0000_1000, 32'h0000_0011, 4'd2, 4'd0);
    south_pkt[1] = make_pkt(op_load, finish_addr_lp, 32'h0000_0022, 4'd2, 4'd1);
    south_pkt[2] = make_pkt(op_store, 32'h0000_EAD4, 32'h0000_0033, 4'd2, 4'd2);
    south_v      = '1;
    @(posedge clk);
    #1 south_v = '0;
    @(negedge clk);
    check(!finish && !fail && (status_code == '0), "flags set by a non-matching packet");
    @(posedge clk);
    #1;
    // channel 0 carries a finish store but is not valid
    south_pkt[0] = make_pkt(op_store, finish_addr_lp, 32'hBAD0_0000, 4'd2, 4'd0);
    south_pkt[1] = make_pkt(op_store, finish_addr_lp, 32'h0000_0F1E, 4'd2, 4'd1);
    south_pkt[2] = make_pkt(op_store, fail_addr_lp, 32'h0000_0FA2, 4'd2, 4'd2);
    south_v      = 3'b110;
    @(negedge clk);
    check(!finish && !fail, "flags set before the capturing edge");
    @(posedge clk);
    #1 south_v = '0;
    @(negedge clk);
    check(finish, "finish_o low after a finish store");
    check(fail, "fail_o low after a fail store");
    check(status_code == 32'h0000_0F1E,
          $sformatf("status_code_o is %h, expected 00000f1e", status_code));
    @(posedge clk);
    #1;
    south_pkt[0] = make_pkt(op_store, fail_addr_lp, 32'h0000_5A5A, 4'd2, 4'd0);
    south_v      = 3'b001;
    @(posedge clk);
    #1 south_v = '0;
    repeat (10)
    begin
      @(negedge clk);
      check(finish && fail, "a sticky flag dropped");
      check(status_code == 32'h0000_0F1E, "status code replaced by a later report");
      check(!timeout, "timeout_o high during the first run");
    end
  endtask

  task automatic run_timeout();
    int cyc;
    cyc = 0;
    apply_reset();
    @(negedge clk);
    check(!finish && !fail && !timeout && (status_code == '0), "monitor not cleared by reset");
    while (!timeout && cyc < max_cycles_lp + 10)
    begin
      @(negedge clk);
      cyc++;
      check(!finish, "finish_o rose without south traffic");
    end
    if (!timeout)
      timed_out("timeout_o");
    else
      check(cyc >= max_cycles_lp, $sformatf("timeout_o rose early, after %0d cycles", cyc));
  endtask

  initial
  begin
    rst_n        = 1'b0;
    net_ready    = 1'b0;
    south_pkt    = '0;
    south_v      = '0;
    lcg_state    = 32'ha82;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_err0    = 0;
    build_expected();
    apply_reset();

    start_test();
    @(negedge clk);
    check(!net_v && !load_done, "loader outputs high after reset");
    check(!finish && !fail && !timeout, "monitor flags high after reset");
    check(status_code == '0, "status_code_o not zero after reset");
    end_test("reset_values");

    start_test();
    run_load();
    end_test("spmd_load");

    start_test();
    run_monitor();
    end_test("south_monitor");

    start_test();
    run_timeout();
    end_test("cycle_timeout");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* hdl/host_top.sv */
`timescale 1ns/1ps

module host_top
#(
  parameter int num_rows_p   = 2,
  parameter int num_cols_p   = 2,
  parameter int mem_words_p  = 8,
  parameter int max_cycles_p = 100000
)
(
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  output host_cfg_pkg::word_idx_t                rom_addr_o,
  input  noc_pkt_pkg::data_t                     rom_data_i,
  output noc_pkt_pkg::noc_pkt_t                  net_pkt_o,
  output logic                                   net_v_o,
  input  logic                                   net_ready_i,
  output logic                                   load_done_o,
  input  noc_pkt_pkg::noc_pkt_t [num_cols_p-1:0] south_pkt_i,
  input  logic                  [num_cols_p-1:0] south_v_i,
  output logic                                   finish_o,
  output logic                                   fail_o,
  output logic                                   timeout_o,
  output noc_pkt_pkg::data_t                     status_code_o
);
  import noc_pkt_pkg::*;
  import host_cfg_pkg::*;

  load_item_t item;
  logic       item_v;
  logic       item_ready;
  noc_pkt_t   pkt;
  logic       pkt_v;
  logic       pkt_ready;

  spmd_fetch #(
    .num_rows_p  (num_rows_p),
    .num_cols_p  (num_cols_p),
    .mem_words_p (mem_words_p)
  ) u_fetch (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rom_addr_o   (rom_addr_o),
    .rom_data_i   (rom_data_i),
    .item_o       (item),
    .item_v_o     (item_v),
    .item_ready_i (item_ready),
    .net_v_i      (net_v_o),      // watches the network handshake for done
    .net_ready_i  (net_ready_i),
    .done_o       (load_done_o)
  );

  spmd_pkt_builder u_builder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .item_i       (item),
    .item_v_i     (item_v),
    .item_ready_o (item_ready),
    .pkt_o        (pkt),
    .pkt_v_o      (pkt_v),
    .pkt_ready_i  (pkt_ready)
  );

  net_egress_buf u_egress (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .pkt_i       (pkt),
    .pkt_v_i     (pkt_v),
    .pkt_ready_o (pkt_ready),
    .net_pkt_o   (net_pkt_o),
    .net_v_o     (net_v_o),
    .net_ready_i (net_ready_i)
  );

  south_edge_monitor #(
    .num_cols_p   (num_cols_p),
    .max_cycles_p (max_cycles_p)
  ) u_monitor (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .south_pkt_i   (south_pkt_i),
    .south_v_i     (south_v_i),
    .finish_o      (finish_o),
    .fail_o        (fail_o),
    .timeout_o     (timeout_o),
    .status_code_o (status_code_o)
  );

endmodule

/* hdl/south_edge_monitor.sv */
`timescale 1ns/1ps

module south_edge_monitor
#(
  parameter int num_cols_p   = 4,
  parameter int max_cycles_p = 100000
)
(
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  noc_pkt_pkg::noc_pkt_t [num_cols_p-1:0] south_pkt_i,
  input  logic                  [num_cols_p-1:0] south_v_i,
  output logic                                   finish_o,
  output logic                                   fail_o,
  output logic                                   timeout_o,
  output noc_pkt_pkg::data_t                     status_code_o
);
  import noc_pkt_pkg::*;
  import host_cfg_pkg::*;

  localparam int cyc_w_lp = $clog2(max_cycles_p + 1);

  typedef logic [cyc_w_lp-1:0] cyc_cnt_t;

  localparam cyc_cnt_t cyc_limit_lp = cyc_cnt_t'(max_cycles_p);

  logic [num_cols_p-1:0] finish_hit;
  logic [num_cols_p-1:0] fail_hit;
  data_t                 hit_data;
  logic                  any_hit;
  logic                  finish_q;
  logic                  fail_q;
  logic                  timeout_q;
  data_t                 status_q;
  cyc_cnt_t              cyc_q;

  for (genvar c = 0; c < num_cols_p; c++)
  begin : g_dec
    logic is_store;
    assign is_store      = south_v_i[c] && (south_pkt_i[c].op == op_store);
    assign finish_hit[c] = is_store && (south_pkt_i[c].addr == finish_addr_c);
    assign fail_hit[c]   = is_store && (south_pkt_i[c].addr == fail_addr_c);
  end

  assign any_hit = |(finish_hit | fail_hit);

  // scan downward so the lowest channel lands last
  always_comb
  begin
    hit_data = '0;
    for (int c = num_cols_p - 1; c >= 0; c--)
      if (finish_hit[c] || fail_hit[c])
        hit_data = south_pkt_i[c].data;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      finish_q  <= 1'b0;
      fail_q    <= 1'b0;
      timeout_q <= 1'b0;
      status_q  <= '0;
      cyc_q     <= '0;
    end
    else
    begin
      if (|finish_hit)
        finish_q <= 1'b1;
      if (|fail_hit)
        fail_q <= 1'b1;
      if (any_hit && !finish_q && !fail_q)
        status_q <= hit_data;  // first report only
      if (cyc_q != cyc_limit_lp)
        cyc_q <= cyc_q + 1'b1;
      if ((cyc_q == cyc_limit_lp) && !finish_q && !fail_q)
        timeout_q <= 1'b1;
    end
  end

  assign finish_o      = finish_q;
  assign fail_o        = fail_q;
  assign timeout_o     = timeout_q;
  assign status_code_o = status_q;

endmodule

/* hdl/net_egress_buf.sv */
`timescale 1ns/1ps

module net_egress_buf
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  noc_pkt_pkg::noc_pkt_t pkt_i,
  input  logic                  pkt_v_i,
  output logic                  pkt_ready_o,
  output noc_pkt_pkg::noc_pkt_t net_pkt_o,
  output logic                  net_v_o,
  input  logic                  net_ready_i
);
  import noc_pkt_pkg::*;

  noc_pkt_t   mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  // ready comes from the count only, never from net_ready_i
  assign pkt_ready_o = (count_q != 2'd2);
  assign net_v_o     = (count_q != 2'd0);
  assign net_pkt_o   = mem_q[rd_ptr_q];  // head holds until popped

  assign push = pkt_v_i && pkt_ready_o;
  assign pop  = net_v_o && net_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ~wr_ptr_q;
      if (pop)
        rd_ptr_q <= ~rd_ptr_q;
      unique case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_q[wr_ptr_q] <= pkt_i;
  end

endmodule

/* hdl/spmd_pkt_builder.sv */
`timescale 1ns/1ps

module spmd_pkt_builder
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  host_cfg_pkg::load_item_t item_i,
  input  logic                     item_v_i,
  output logic                     item_ready_o,
  output noc_pkt_pkg::noc_pkt_t    pkt_o,
  output logic                     pkt_v_o,
  input  logic                     pkt_ready_i
);
  import noc_pkt_pkg::*;
  import host_cfg_pkg::*;

  noc_pkt_t pkt_d;
  noc_pkt_t pkt_q;
  logic     pkt_v_q;
  logic     load;

  assign item_ready_o = !pkt_v_q || pkt_ready_i;  // empty or draining
  assign load         = item_v_i && item_ready_o;

  always_comb
  begin
    pkt_d.op     = op_store;
    pkt_d.op_ex  = op_ex_full_c;
    pkt_d.y_cord = item_i.y_cord;
    pkt_d.x_cord = item_i.x_cord;
    if (item_i.phase == phase_unfreeze)
    begin
      pkt_d.addr = freeze_addr_c;
      pkt_d.data = '0;
    end
    else
    begin
      pkt_d.addr = addr_t'({item_i.word, 2'b00});  // word to byte address
      pkt_d.data = item_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      pkt_v_q <= 1'b0;
    else if (load)
      pkt_v_q <= 1'b1;
    else if (pkt_ready_i)
      pkt_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
      pkt_q <= pkt_d;
  end

  assign pkt_o   = pkt_q;
  assign pkt_v_o = pkt_v_q;

endmodule

/* hdl/spmd_fetch.sv */
`timescale 1ns/1ps

module spmd_fetch
#(
  parameter int num_rows_p  = 2,
  parameter int num_cols_p  = 2,
  parameter int mem_words_p = 8
)
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  output host_cfg_pkg::word_idx_t  rom_addr_o,
  input  noc_pkt_pkg::data_t       rom_data_i,
  output host_cfg_pkg::load_item_t item_o,
  output logic                     item_v_o,
  input  logic                     item_ready_i,
  input  logic                     net_v_i,
  input  logic                     net_ready_i,
  output logic                     done_o
);
  import noc_pkt_pkg::*;
  import host_cfg_pkg::*;

  localparam int unsigned total_pkts_lp = num_rows_p * num_cols_p * (mem_words_p + 1);
  localparam int sent_w_lp = $clog2(total_pkts_lp + 1);

  localparam word_idx_t last_word_lp = word_idx_t'(mem_words_p - 1);
  localparam x_cord_t   last_col_lp  = x_cord_t'(num_cols_p - 1);
  localparam y_cord_t   last_row_lp  = y_cord_t'(num_rows_p - 1);

  fetch_state_t         state_q;
  word_idx_t            word_q;
  x_cord_t              x_q;
  y_cord_t              y_q;
  logic                 item_v_q;
  load_item_t           item_q;
  logic [sent_w_lp-1:0] sent_q;
  logic                 done_q;

  logic fetch_en;
  logic last_word;
  logic last_tile;
  logic tile_step;
  logic net_xfer;

  // idle fetches word 0 right away, so it acts as the first program step
  assign fetch_en  = (state_q != done_s) && (!item_v_q || item_ready_i);
  assign last_word = (word_q == last_word_lp);
  assign last_tile = (x_q == last_col_lp) && (y_q == last_row_lp);
  assign tile_step = fetch_en && ((state_q == unfreeze_s) || last_word);
  assign net_xfer  = net_v_i && net_ready_i;

  assign rom_addr_o = word_q;
  assign item_o     = item_q;
  assign item_v_o   = item_v_q;
  assign done_o     = done_q;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= idle_s;
      word_q  <= '0;
    end
    else if (fetch_en)
    begin
      unique case (state_q)
        idle_s, program_s:
        begin
          word_q  <= last_word ? '0 : word_q + 1'b1;
          state_q <= (last_word && last_tile) ? unfreeze_s : program_s;
        end
        unfreeze_s:
          if (last_tile)
            state_q <= done_s;
        default:
          state_q <= done_s;
      endcase
    end
  end

  // row by row, x inner
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      x_q <= '0;
      y_q <= '0;
    end
    else if (tile_step)
    begin
      if (x_q == last_col_lp)
      begin
        x_q <= '0;
        y_q <= (y_q == last_row_lp) ? '0 : y_q + 1'b1;
      end
      else
        x_q <= x_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      item_v_q <= 1'b0;
    else if (fetch_en)
      item_v_q <= 1'b1;
    else if (item_ready_i)
      item_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (fetch_en)
    begin
      item_q.phase  <= (state_q == unfreeze_s) ? phase_unfreeze : phase_program;
      item_q.word   <= word_q;
      item_q.data   <= rom_data_i;  // rom is combinational
      item_q.y_cord <= y_q;
      item_q.x_cord <= x_q;
    end
  end

  // done once the final packet has left on the network
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sent_q <= '0;
      done_q <= 1'b0;
    end
    else if (net_xfer && !done_q)
    begin
      sent_q <= sent_q + 1'b1;
      if ((sent_q == sent_w_lp'(total_pkts_lp - 1)) && (state_q == done_s))
        done_q <= 1'b1;
    end
  end

endmodule

/* hdl/host_cfg_pkg.sv */
package host_cfg_pkg;

  // addresses the tiles store to when they end a run
  localparam noc_pkt_pkg::addr_t finish_addr_c = 32'h0000_EAD0;
  localparam noc_pkt_pkg::addr_t fail_addr_c   = 32'h0000_EAD8;

  // a store here releases the tile from freeze
  localparam noc_pkt_pkg::addr_t freeze_addr_c = 32'h0000_FF00;

  typedef logic [15:0] word_idx_t;  // program ROM word index

  typedef enum logic
  {
    phase_program  = 1'b0,
    phase_unfreeze = 1'b1
  } load_phase_t;

  typedef struct packed
  {
    load_phase_t          phase;
    word_idx_t            word;
    noc_pkt_pkg::data_t   data;
    noc_pkt_pkg::y_cord_t y_cord;
    noc_pkt_pkg::x_cord_t x_cord;
  } load_item_t;

  typedef enum logic [1:0]
  {
    idle_s     = 2'd0,
    program_s  = 2'd1,
    unfreeze_s = 2'd2,
    done_s     = 2'd3
  } fetch_state_t;

endpackage

/* hdl/noc_pkt_pkg.sv */
package noc_pkt_pkg;

  // mesh coordinates, one nibble each
  typedef logic [3:0]  x_cord_t;
  typedef logic [3:0]  y_cord_t;

  typedef logic [31:0] addr_t;   // byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  op_ex_t;  // byte mask

  localparam op_ex_t op_ex_full_c = 4'hF;

  typedef enum logic [1:0]
  {
    op_load  = 2'd0,
    op_store = 2'd1
  } op_t;

  // field order follows the manycore remote packet
  typedef struct packed
  {
    op_t     op;
    op_ex_t  op_ex;
    addr_t   addr;
    data_t   data;
    y_cord_t y_cord;
    x_cord_t x_cord;
  } noc_pkt_t;

endpackage
